/* hw/accum_defs.svh */
// Datapath width and channel count, included by the package and the RTL files
`ifndef ACCUM_DEFS_SVH
`define ACCUM_DEFS_SVH

// Fixed at 32 by the pairing in the Ling adder
`define ACCUM_WIDTH 32

// One adder shared by this many clients
`define ACCUM_CHANNELS 2

`endif

/* hw/accum_pkg.sv */
// Shared word, operand and channel index types used across the accumulator RTL
`include "accum_defs.svh"

package accum_pkg;

  typedef logic [`ACCUM_WIDTH-1:0] word_t;

  typedef struct packed {
    word_t a;
    word_t b;
    logic  cin;  // 1 for subtract
  } operand_t;

  typedef logic chan_idx_t;

endpackage

/* hw/adder_port_if.sv */
// Link between one accumulator channel and the adder arbiter, one per client
interface adder_port_if;

  logic                req;  // Held with op until gnt
  logic                gnt;  // Never without req
  accum_pkg::operand_t op;
  accum_pkg::word_t    sum;  // Valid in the granted cycle

  modport client (
    output req,
    output op,
    input  gnt,
    input  sum
  );

  modport arbiter (
    input  req,
    input  op,
    output gnt,
    output sum
  );

endinterface

/* hw/ling_adder32.sv */
// Combinational 32-bit Ling parallel-prefix adder with carry-in, shared by both channels
`include "accum_defs.svh"

module ling_adder32 (
  input  accum_pkg::word_t a,
  input  accum_pkg::word_t b,
  input  logic             cin,
  output accum_pkg::word_t s
);

  localparam int PAIRS  = `ACCUM_WIDTH / 2;
  localparam int LEVELS = $clog2(PAIRS);

  accum_pkg::word_t g;  // Bit generate
  accum_pkg::word_t p;  // Half sum
  accum_pkg::word_t t;  // Bit transmit

  wire [PAIRS-1:0] h;     // Pair pseudo generate
  wire [PAIRS-1:0] t_in;  // Transmit of the bit just below a pair
  wire [PAIRS-1:0] tp;    // Pair transmit, shifted one bit down
  wire [PAIRS-1:0] hc;    // Ling pseudo carry into each pair

  // Prefix tree nodes, one row per level
  wire [PAIRS-1:0] gg [0:LEVELS];
  wire [PAIRS-1:0] pp [0:LEVELS-1];

  wire [`ACCUM_WIDTH-1:0] s0;     // Pair sums for pseudo carry 0
  wire [`ACCUM_WIDTH-1:0] s1;     // Pair sums for pseudo carry 1
  wire [`ACCUM_WIDTH-1:0] c_sel;  // Pseudo carry spread over both bits

  assign g = a & b;
  assign p = a ^ b;
  assign t = a | b;

  genvar j;
  genvar l;

  generate
    for (j = 0; j < PAIRS; j++) begin : g_pair
      if (j == 0) begin : g_low
        assign t_in[j]  = 1'b1;  // Real carry equals cin here
        assign gg[0][j] = h[j] | (tp[j] & cin);  // Fold cin into first node
      end else begin : g_upper
        assign t_in[j]  = t[2*j-1];
        assign gg[0][j] = h[j];
      end

      // Ling form drops the upper transmit from the pair generate
      assign h[j]  = g[2*j+1] | g[2*j];
      assign tp[j] = t[2*j] & t_in[j];
      assign pp[0][j] = tp[j];

      // A set pseudo carry means the real carry is t_in
      assign s0[2*j]   = p[2*j];
      assign s1[2*j]   = p[2*j] ^ t_in[j];
      assign s0[2*j+1] = p[2*j+1] ^ g[2*j];
      assign s1[2*j+1] = p[2*j+1] ^ (g[2*j] | (p[2*j] & t_in[j]));

      assign c_sel[2*j]   = hc[j];
      assign c_sel[2*j+1] = hc[j];
    end

    // Kogge-Stone over the pair terms
    for (l = 0; l < LEVELS; l++) begin : g_level
      for (j = 0; j < PAIRS; j++) begin : g_node
        if (j >= (1 << l)) begin : g_merge
          assign gg[l+1][j] = gg[l][j] | (pp[l][j] & gg[l][j-(1<<l)]);
          if (l < LEVELS - 1) begin : g_tp
            assign pp[l+1][j] = pp[l][j] & pp[l][j-(1<<l)];
          end
        end else begin : g_pass
          assign gg[l+1][j] = gg[l][j];
          if (l < LEVELS - 1) begin : g_tp
            assign pp[l+1][j] = pp[l][j];
          end
        end
      end
    end

    for (j = 0; j < PAIRS; j++) begin : g_carry
      if (j == 0) begin : g_cin
        assign hc[j] = cin;
      end else begin : g_tree
        assign hc[j] = gg[LEVELS][j-1];  // Top node covers pairs below j
      end
    end
  endgenerate

  assign s = (s1 & c_sel) | (s0 & ~c_sel);

endmodule

/* hw/adder_arbiter.sv */
// Round-robin arbiter that shares the single adder between the two client ports
`include "accum_defs.svh"

module adder_arbiter (
  input  logic             clk,
  input  logic             rst,
  adder_port_if.arbiter    cl0,
  adder_port_if.arbiter    cl1,
  output accum_pkg::word_t add_a,
  output accum_pkg::word_t add_b,
  output logic             add_cin,
  input  accum_pkg::word_t add_s
);

  logic [`ACCUM_CHANNELS-1:0] req;
  logic [`ACCUM_CHANNELS-1:0] gnt;
  accum_pkg::chan_idx_t       last_q;  // Channel granted most recently
  accum_pkg::chan_idx_t       sel;
  accum_pkg::operand_t        op_sel;

  assign req = {cl1.req, cl0.req};

  always_comb begin
    if (req[0] && req[1]) begin
      sel = ~last_q;  // Contention goes to the other channel
    end else begin
      sel = req[1];
    end
  end

  assign gnt = req & (`ACCUM_CHANNELS'(1) << sel);

  assign cl0.gnt = gnt[0];
  assign cl1.gnt = gnt[1];

  assign op_sel  = sel ? cl1.op : cl0.op;
  assign add_a   = op_sel.a;
  assign add_b   = op_sel.b;
  assign add_cin = op_sel.cin;

  // Only the granted client takes the sum
  assign cl0.sum = add_s;
  assign cl1.sum = add_s;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_q <= 1'b1;  // First contention goes to channel 0
    end else if (|gnt) begin
      last_q <= sel;
    end
  end

endmodule

/* hw/channel_accumulator.sv */
// One accumulator channel with a single pending slot, requesting the shared adder
module channel_accumulator (
  input  logic             clk,
  input  logic             rst,
  input  logic             valid,
  input  logic             sub,
  input  logic             clear,
  input  accum_pkg::word_t data,
  output accum_pkg::word_t acc,
  output logic             busy,
  adder_port_if.client     port
);

  logic             pend_q;  // Slot holds an operand
  logic             sub_q;
  accum_pkg::word_t data_q;
  accum_pkg::word_t b_term;

  always_ff @(posedge clk) begin
    if (rst || clear) begin  // Clear beats valid
      pend_q <= 1'b0;
      acc    <= '0;
    end else if (pend_q) begin
      if (port.gnt) begin
        pend_q <= 1'b0;
        acc    <= port.sum;
      end
    end else begin
      pend_q <= valid;  // Strobe while busy is dropped
    end
  end

  always_ff @(posedge clk) begin
    if (!pend_q && valid) begin
      data_q <= data;
      sub_q  <= sub;
    end
  end

  // Subtract as inverted operand plus one
  assign b_term = sub_q ? ~data_q : data_q;

  assign port.req = pend_q;
  assign port.op  = '{a: acc, b: b_term, cin: sub_q};

  assign busy = pend_q;

endmodule

/* hw/dual_accum_top.sv */
// Top level of the two-channel accumulator, plain ports for each channel
`include "accum_defs.svh"

module dual_accum_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             ch0_valid,
  input  logic             ch0_sub,
  input  logic             ch0_clear,
  input  accum_pkg::word_t ch0_data,
  output accum_pkg::word_t ch0_acc,
  output logic             ch0_busy,
  input  logic             ch1_valid,
  input  logic             ch1_sub,
  input  logic             ch1_clear,
  input  accum_pkg::word_t ch1_data,
  output accum_pkg::word_t ch1_acc,
  output logic             ch1_busy
);

  adder_port_if port_if [`ACCUM_CHANNELS] ();

  accum_pkg::word_t add_a;
  accum_pkg::word_t add_b;
  accum_pkg::word_t add_s;
  logic             add_cin;

  channel_accumulator ch0_acc_u (
    .clk   (clk),
    .rst   (rst),
    .valid (ch0_valid),
    .sub   (ch0_sub),
    .clear (ch0_clear),
    .data  (ch0_data),
    .acc   (ch0_acc),
    .busy  (ch0_busy),
    .port  (port_if[0])
  );

  channel_accumulator ch1_acc_u (
    .clk   (clk),
    .rst   (rst),
    .valid (ch1_valid),
    .sub   (ch1_sub),
    .clear (ch1_clear),
    .data  (ch1_data),
    .acc   (ch1_acc),
    .busy  (ch1_busy),
    .port  (port_if[1])
  );

  adder_arbiter arb_u (
    .clk     (clk),
    .rst     (rst),
    .cl0     (port_if[0]),
    .cl1     (port_if[1]),
    .add_a   (add_a),
    .add_b   (add_b),
    .add_cin (add_cin),
    .add_s   (add_s)
  );

  ling_adder32 adder_u (
    .a   (add_a),
    .b   (add_b),
    .cin (add_cin),
    .s   (add_s)
  );

endmodule

/* tests/dual_accum_checker.sv */
// Timing rules of the accumulator top level, bound into every dual_accum_top instance
module dual_accum_checker (
  input logic             clk,
  input logic             rst,
  input logic             ch0_valid,
  input logic             ch0_clear,
  input logic             ch0_busy,
  input accum_pkg::word_t ch0_acc,
  input logic             ch1_valid,
  input logic             ch1_clear,
  input logic             ch1_busy,
  input accum_pkg::word_t ch1_acc
);

  timeunit 1ns;
  timeprecision 1ps;

  int violations = 0;  // Read by the testbench at the end

  // Clear also drops busy, so it satisfies the bound as well
  busy0_bound: assert property (@(posedge clk) disable iff (rst)
    $rose(ch0_busy) |-> ##[1:2] !ch0_busy)
    else begin violations++; $error("ch0 busy held longer than 2 cycles"); end
  busy1_bound: assert property (@(posedge clk) disable iff (rst)
    $rose(ch1_busy) |-> ##[1:2] !ch1_busy)
    else begin violations++; $error("ch1 busy held longer than 2 cycles"); end

  acc0_hold: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) && !$past(ch0_busy) && !$past(ch0_clear) |-> $stable(ch0_acc))
    else begin violations++; $error("ch0 acc changed while idle"); end
  acc1_hold: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) && !$past(ch1_busy) && !$past(ch1_clear) |-> $stable(ch1_acc))
    else begin violations++; $error("ch1 acc changed while idle"); end

  strobe0_idle: assert property (@(posedge clk) disable iff (rst) !(ch0_valid && ch0_busy))
    else begin violations++; $error("ch0 strobed while busy"); end
  strobe1_idle: assert property (@(posedge clk) disable iff (rst) !(ch1_valid && ch1_busy))
    else begin violations++; $error("ch1 strobed while busy"); end

endmodule

bind dual_accum_top dual_accum_checker chk_u (.*);

/* tests/dual_accum_tb.sv */
// Testbench for the two-channel accumulator, runs a stimulus table then random rows
module dual_accum_tb;

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [1:0]       valid;  // Bit n strobes channel n
    logic [1:0]       sub;
    logic [1:0]       clear;
    accum_pkg::word_t d0;
    accum_pkg::word_t d1;
  } row_t;

  logic             clk;
  logic             rst;
  logic             ch0_valid;
  logic             ch0_sub;
  logic             ch0_clear;
  accum_pkg::word_t ch0_data;
  accum_pkg::word_t ch0_acc;
  logic             ch0_busy;
  logic             ch1_valid;
  logic             ch1_sub;
  logic             ch1_clear;
  accum_pkg::word_t ch1_data;
  accum_pkg::word_t ch1_acc;
  logic             ch1_busy;

  row_t             rows [$];
  accum_pkg::word_t model [2];
  logic             last_gnt;  // Model of the arbiter pointer
  integer           seed;
  int               checks;
  int               value_errors;
  int               other_errors;

  dual_accum_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reference rule: clear gives 0, then add or subtract modulo 2^32
  function automatic accum_pkg::word_t next_acc(input accum_pkg::word_t acc, input logic v,
                                                input logic s, input logic c,
                                                input accum_pkg::word_t d);
    if (c) return '0;
    if (!v) return acc;
    return s ? acc - d : acc + d;
  endfunction

  task automatic push_row(input logic [1:0] v, input logic [1:0] s, input logic [1:0] c,
                          input accum_pkg::word_t d0, input accum_pkg::word_t d1);
    rows.push_back('{v, s, c, d0, d1});
  endtask

  task automatic compare_acc(input string name, input accum_pkg::word_t got,
                             input accum_pkg::word_t exp);
    checks++;
    assert (got === exp) else begin
      value_errors++;
      $display("[FAIL] %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic apply_row(input row_t r);
    int   waits;
    int   done0;
    int   done1;
    int   exp0;
    int   exp1;
    logic go0;
    logic go1;
    go0  = r.valid[0] && !r.clear[0];
    go1  = r.valid[1] && !r.clear[1];
    exp0 = go0 ? 1 : 0;
    exp1 = go1 ? 1 : 0;
    if (go0 && go1) begin  // Loser goes one cycle later and stays the last granted
      if (last_gnt) begin
        exp1 = 2;
      end else begin
        exp0 = 2;
      end
    end else if (go0) begin
      last_gnt = 1'b0;
    end else if (go1) begin
      last_gnt = 1'b1;
    end
    ch0_valid = r.valid[0];
    ch0_sub   = r.sub[0];
    ch0_clear = r.clear[0];
    ch0_data  = r.d0;
    ch1_valid = r.valid[1];
    ch1_sub   = r.sub[1];
    ch1_clear = r.clear[1];
    ch1_data  = r.d1;
    model[0] = next_acc(model[0], r.valid[0], r.sub[0], r.clear[0], r.d0);
    model[1] = next_acc(model[1], r.valid[1], r.sub[1], r.clear[1], r.d1);
    @(posedge clk);
    #1;
    ch0_valid = 1'b0;
    ch0_clear = 1'b0;
    ch1_valid = 1'b0;
    ch1_clear = 1'b0;
    waits = 0;
    done0 = ch0_busy ? -1 : 0;
    done1 = ch1_busy ? -1 : 0;
    while ((ch0_busy || ch1_busy) && waits < 4) begin
      @(posedge clk);
      #1;
      waits++;
      if (!ch0_busy && done0 < 0) done0 = waits;
      if (!ch1_busy && done1 < 0) done1 = waits;
    end
    checks++;
    if (ch0_busy || ch1_busy) begin
      assert (0) else begin
        other_errors++;
        $display("Timeout: busy still high 4 cycles after a strobe");
      end
    end else begin
      assert (done0 == exp0) else begin
        other_errors++;
        $display("ch0 busy fell after %0d cycles where %0d were expected", done0, exp0);
      end
      assert (done1 == exp1) else begin
        other_errors++;
        $display("ch1 busy fell after %0d cycles where %0d were expected", done1, exp1);
      end
    end
    compare_acc("ch0_acc", ch0_acc, model[0]);
    compare_acc("ch1_acc", ch1_acc, model[1]);
  endtask

  task automatic build_table();
    push_row(2'b01, 2'b00, 2'b00, 32'hFFFF_FFFF, 32'h0);  // Full carry chain next
    push_row(2'b01, 2'b00, 2'b00, 32'h0000_0001, 32'h0);
    push_row(2'b10, 2'b00, 2'b00, 32'h0, 32'h7FFF_FFFF);
    push_row(2'b10, 2'b00, 2'b00, 32'h0, 32'h0000_0001);
    push_row(2'b01, 2'b00, 2'b00, 32'h7FFF_FFFF, 32'h0);
    push_row(2'b01, 2'b00, 2'b00, 32'h0000_0001, 32'h0);
    push_row(2'b01, 2'b01, 2'b00, 32'h8000_0001, 32'h0);  // Goes below zero
    push_row(2'b10, 2'b10, 2'b00, 32'h0, 32'h0000_0005);
    push_row(2'b11, 2'b11, 2'b00, 32'h0000_0010, 32'h7FFF_FFFF);
    push_row(2'b11, 2'b00, 2'b00, 32'h1234_5678, 32'h9ABC_DEF0);
    for (int k = 0; k < 8; k++) begin
      push_row(2'b11, k[1:0], 2'b00, 32'h0101_0101 * (k + 1), 32'hF0F0_0F0F ^ k);
    end
    push_row(2'b00, 2'b00, 2'b01, 32'h0, 32'h0);  // Clear channel 0 only
    push_row(2'b10, 2'b00, 2'b10, 32'h0, 32'h0000_0055);  // Clear beats valid
    push_row(2'b01, 2'b00, 2'b00, 32'h0000_0003, 32'h0);  // Next contention goes to ch1
    push_row(2'b11, 2'b10, 2'b00, 32'hDEAD_BEEF, 32'h0000_0001);
  endtask

  function automatic row_t random_row();
    row_t r;
    r.valid    = 2'($random(seed));
    r.sub      = 2'($random(seed));
    r.clear[0] = ($random(seed) & 7) == 0;
    r.clear[1] = ($random(seed) & 7) == 0;
    r.d0       = $random(seed);
    r.d1       = $random(seed);
    return r;
  endfunction

  initial begin
    {ch0_valid, ch0_sub, ch0_clear, ch1_valid, ch1_sub, ch1_clear} = '0;
    ch0_data = '0;
    ch1_data = '0;
    rst = 1'b1;
    seed = 32'he577;
    checks = 0;
    value_errors = 0;
    other_errors = 0;
    model[0] = '0;
    model[1] = '0;
    last_gnt = 1'b1;  // Channel 0 wins the first contention
    build_table();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    compare_acc("ch0_acc", ch0_acc, '0);
    compare_acc("ch1_acc", ch1_acc, '0);
    foreach (rows[i]) apply_row(rows[i]);
    repeat (40) apply_row(random_row());
    assert (dut0.chk_u.violations == 0) else begin
      other_errors++;
      $display("Bound assertions failed %0d times", dut0.chk_u.violations);
    end
    $display("Checks %0d, value errors %0d, other errors %0d", checks, value_errors,
             other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+hw
hw/accum_pkg.sv
hw/adder_port_if.sv
hw/ling_adder32.sv
hw/adder_arbiter.sv
hw/channel_accumulator.sv
hw/dual_accum_top.sv
tests/dual_accum_checker.sv
tests/dual_accum_tb.sv

/* Bender.yml */
package:
  name: dual_accum

sources:
  - include_dirs:
      - hw
    files:
      - hw/accum_pkg.sv
      - hw/adder_port_if.sv
      - hw/ling_adder32.sv
      - hw/adder_arbiter.sv
      - hw/channel_accumulator.sv
      - hw/dual_accum_top.sv
  - target: test
    files:
      - tests/dual_accum_checker.sv
      - tests/dual_accum_tb.sv
